//--- design/bridge_map_pkg.sv
//////////////////////////////////////////////////////////////////////
// bridge map package
// host bridge addresses, ROM loading region and bus widths
//////////////////////////////////////////////////////////////////////

package bridge_map_pkg;

  // bridge words
  typedef logic [31:0] bridge_addr_t;
  typedef logic [31:0] bridge_data_t;

  // settings registers
  localparam bridge_addr_t ADDR_RESET  = 32'h0000_0000;
  localparam bridge_addr_t ADDR_SOUND  = 32'h0000_0010;
  localparam bridge_addr_t ADDR_TURBO  = 32'h0000_0100;
  localparam bridge_addr_t ADDR_CANCEL = 32'h0000_0104;

  // upper address nibble of the program ROM window
  localparam logic [3:0] ROM_REGION = 4'h1;

  // program store, 16 bit words with 12 bit instructions
  localparam int ROM_DEPTH = 8192;

  typedef logic [$clog2(ROM_DEPTH)-1:0] rom_word_addr_t;
  typedef logic [15:0]                  rom_word_t;
  typedef logic [11:0]                  rom_insn_t;

endpackage

//--- design/pacing_pkg.sv
//////////////////////////////////////////////////////////////////////
// pacing package
// turbo speeds, CPU clock divider counts and reset lengths
//////////////////////////////////////////////////////////////////////

package pacing_pkg;

  typedef enum logic [1:0] {
    TURBO_1X   = 2'd0,
    TURBO_4X   = 2'd1,
    TURBO_50X  = 2'd2,
    TURBO_FULL = 2'd3
  } turbo_t;

  // divider reload values, 117.964 MHz down to the CPU rate
  typedef logic [11:0] div_count_t;

  localparam div_count_t BASE_DIV_COUNT = 12'd3600;
  localparam div_count_t DIV_COUNT_4X   = div_count_t'(BASE_DIV_COUNT / 4);
  localparam div_count_t DIV_COUNT_50X  = div_count_t'(BASE_DIV_COUNT / 50);

  // reset lengths
  localparam int EXT_RESET_CYCLES = 64;
  localparam int SS_RESET_TICKS   = 4;

  typedef logic [$clog2(EXT_RESET_CYCLES+1)-1:0] ext_count_t;
  typedef logic [$clog2(SS_RESET_TICKS+1)-1:0]   ss_tick_t;

  // audio sample, buzzer drives the low bits only
  typedef logic [14:0] audio_t;
  localparam int AUDIO_ON_BITS = 13;

endpackage

//--- design/settings_if.sv
//////////////////////////////////////////////////////////////////////
// settings interface
// host settings from the register block to the CPU pacing logic
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

interface settings_if;
  import pacing_pkg::*;

  turbo_t turbo;
  logic   sound_off;
  logic   cancel_on_event;
  logic   ext_reset;
  // single cycle request to drop back to 1x
  logic   cancel_turbo;

  modport owner (
    output turbo, sound_off, cancel_on_event, ext_reset,
    input  cancel_turbo
  );

  modport user (
    input  turbo, sound_off, cancel_on_event, ext_reset,
    output cancel_turbo
  );

endinterface

//--- design/core_settings.sv
//////////////////////////////////////////////////////////////////////
// core settings
// bridge write decode for turbo, sound and cancel settings, the timed
// external reset and the turbo readback
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module core_settings (
  input  logic                        clk_sys_117_964,
  input  logic                        reset_turbo_s,
  input  bridge_map_pkg::bridge_addr_t bridge_addr,
  input  logic                        bridge_wr,
  input  bridge_map_pkg::bridge_data_t bridge_wr_data,
  output bridge_map_pkg::bridge_data_t bridge_rd_data,
  settings_if.owner                   settings
);
  import bridge_map_pkg::*;
  import pacing_pkg::*;

  ext_count_t reset_delay;

  //////////////////////////////////////////////////////////////////////
  // settings registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_sys_117_964) begin
    if (reset_turbo_s) begin
      settings.turbo           <= TURBO_1X;
      settings.sound_off       <= 1'b0;
      settings.cancel_on_event <= 1'b0;
      settings.ext_reset       <= 1'b0;
      reset_delay              <= '0;
    end else begin
      // external reset countdown, flag drops together with the last count
      if (reset_delay != '0) begin
        reset_delay        <= reset_delay - 1'b1;
        settings.ext_reset <= (reset_delay != ext_count_t'(1));
      end

      if (bridge_wr) begin
        case (bridge_addr)
          ADDR_RESET: begin
            reset_delay        <= ext_count_t'(EXT_RESET_CYCLES);
            settings.ext_reset <= 1'b1;
          end
          ADDR_SOUND:  settings.sound_off       <= bridge_wr_data[0];
          ADDR_TURBO:  settings.turbo           <= turbo_t'(bridge_wr_data[1:0]);
          ADDR_CANCEL: settings.cancel_on_event <= bridge_wr_data[0];
          default: ;
        endcase
      end

      // buzzer event wins over a turbo write in the same cycle
      if (settings.cancel_turbo) begin
        settings.turbo <= TURBO_1X;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // readback, only turbo is visible
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    bridge_rd_data = '0;
    if (bridge_addr == ADDR_TURBO) begin
      bridge_rd_data[1:0] = settings.turbo;
    end
  end

  // reset flag and counter must stay in step
  assert property (@(posedge clk_sys_117_964) disable iff (reset_turbo_s)
    settings.ext_reset |-> (reset_delay != '0))
    else $error("ext_reset high with an empty reset counter");

endmodule

//--- design/rom_loader.sv
//////////////////////////////////////////////////////////////////////
// rom loader
// turns 32 bit bridge writes into two byte swapped 16 bit ROM words
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module rom_loader (
  input  logic                          clk_sys_117_964,
  input  logic                          reset_turbo_s,
  input  bridge_map_pkg::bridge_addr_t   bridge_addr,
  input  logic                          bridge_wr,
  input  bridge_map_pkg::bridge_data_t   bridge_wr_data,
  output logic                          wr_en,
  output bridge_map_pkg::rom_word_addr_t wr_addr,
  output bridge_map_pkg::rom_word_t      wr_data
);
  import bridge_map_pkg::*;

  logic      rom_hit;
  logic      pending;
  rom_word_t low_half;

  assign rom_hit = bridge_wr && (bridge_addr[31:28] == ROM_REGION);

  // control state
  always_ff @(posedge clk_sys_117_964) begin
    if (reset_turbo_s) begin
      wr_en   <= 1'b0;
      pending <= 1'b0;
    end else begin
      wr_en   <= rom_hit || pending;
      pending <= rom_hit;
    end
  end

  // payload, bridge data is big endian so the upper half goes first
  always_ff @(posedge clk_sys_117_964) begin
    if (rom_hit) begin
      low_half <= bridge_wr_data[15:0];
      wr_addr  <= bridge_addr[13:1];
      wr_data  <= {bridge_wr_data[23:16], bridge_wr_data[31:24]};
    end else if (pending) begin
      wr_addr <= wr_addr + 1'b1;
      wr_data <= {low_half[7:0], low_half[15:8]};
    end
  end

  // bridge spacing leaves room for the second word
  assert property (@(posedge clk_sys_117_964) disable iff (reset_turbo_s)
    pending |-> !rom_hit)
    else $error("ROM write strobe while the second word is pending");

endmodule

//--- design/program_rom.sv
//////////////////////////////////////////////////////////////////////
// program rom
// 8192 word program store, one write port and one registered read
// port that hands 12 bit instructions to the CPU
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module program_rom (
  input  logic                          clk_sys_117_964,
  input  logic                          wr_en,
  input  bridge_map_pkg::rom_word_addr_t wr_addr,
  input  bridge_map_pkg::rom_word_t      wr_data,
  input  bridge_map_pkg::rom_word_addr_t rom_addr,
  output bridge_map_pkg::rom_insn_t      rom_data
);
  import bridge_map_pkg::*;

  rom_word_t mem [ROM_DEPTH];

  // load port from the bridge
  always_ff @(posedge clk_sys_117_964) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // CPU fetch, upper nibble of each word is unused
  always_ff @(posedge clk_sys_117_964) begin
    rom_data <= mem[rom_addr][$bits(rom_insn_t)-1:0];
  end

endmodule

//--- design/cpu_pacing.sv
//////////////////////////////////////////////////////////////////////
// cpu pacing
// CPU clock enables at four turbo speeds, halt mask, CPU reset,
// turbo cancel on buzzer and the gated audio word
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module cpu_pacing (
  input  logic               clk_sys_117_964,
  input  logic               reset_turbo_s,
  settings_if.user           settings,
  input  logic               buzzer,
  input  logic               ss_begin_reset,
  input  logic               ss_halt,
  output logic               clk_en,
  output logic               clk_2x_en,
  output logic               cpu_reset,
  output pacing_pkg::audio_t audio_l
);
  import pacing_pkg::*;

  div_count_t reload;
  div_count_t div_q;
  logic       full_speed;
  logic       clk_en_q;
  logic       clk_2x_q;
  ss_tick_t   ss_ticks;

  //////////////////////////////////////////////////////////////////////
  // clock divider
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    case (settings.turbo)
      TURBO_1X:   reload = BASE_DIV_COUNT;
      TURBO_4X:   reload = DIV_COUNT_4X;
      TURBO_50X:  reload = DIV_COUNT_50X;
      TURBO_FULL: reload = '0;
    endcase
  end

  assign full_speed = (reload == '0);

  always_ff @(posedge clk_sys_117_964) begin
    if (reset_turbo_s) begin
      div_q    <= BASE_DIV_COUNT;
      clk_en_q <= 1'b0;
      clk_2x_q <= 1'b0;
    end else begin
      clk_en_q <= 1'b0;
      clk_2x_q <= 1'b0;
      if (full_speed) begin
        // 2x every cycle, 1x every other
        clk_en_q <= ~clk_en_q;
        clk_2x_q <= 1'b1;
      end else if (div_q == '0) begin
        div_q    <= reload;
        clk_en_q <= 1'b1;
        clk_2x_q <= 1'b1;
      end else begin
        div_q <= div_q - 1'b1;
        // second 2x tick halfway through the period
        if (div_q == (reload >> 1)) begin
          clk_2x_q <= 1'b1;
        end
      end
    end
  end

  // savestate halt freezes the CPU
  assign clk_en    = clk_en_q & ~ss_halt;
  assign clk_2x_en = clk_2x_q & ~ss_halt;

  //////////////////////////////////////////////////////////////////////
  // savestate reset and turbo cancel
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_sys_117_964) begin
    if (reset_turbo_s) begin
      ss_ticks              <= '0;
      settings.cancel_turbo <= 1'b0;
    end else begin
      if (ss_begin_reset) begin
        ss_ticks <= ss_tick_t'(SS_RESET_TICKS);
      end else if (ss_ticks != '0 && clk_2x_en) begin
        ss_ticks <= ss_ticks - 1'b1;
      end
      settings.cancel_turbo <= settings.cancel_on_event && buzzer;
    end
  end

  assign cpu_reset = reset_turbo_s || settings.ext_reset || (ss_ticks != '0);

  // buzzer as a square wave on the low bits
  always_comb begin
    audio_l = '0;
    if (!settings.sound_off) begin
      audio_l[AUDIO_ON_BITS-1:0] = {AUDIO_ON_BITS{buzzer}};
    end
  end

  // every CPU tick lands on a double rate tick
  assert property (@(posedge clk_sys_117_964) disable iff (reset_turbo_s)
    clk_en |-> clk_2x_en)
    else $error("CPU clock enable without a double rate enable");

endmodule

//--- design/tama_core.sv
//////////////////////////////////////////////////////////////////////
// tama core
// system clock glue between the host bridge and the 4-bit CPU
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tama_core (
  input  logic                          clk_sys_117_964,
  input  logic                          reset_turbo_s,

  // host bridge
  input  bridge_map_pkg::bridge_addr_t   bridge_addr,
  input  logic                          bridge_wr,
  input  bridge_map_pkg::bridge_data_t   bridge_wr_data,
  output bridge_map_pkg::bridge_data_t   bridge_rd_data,

  // CPU side
  input  bridge_map_pkg::rom_word_addr_t rom_addr,
  output bridge_map_pkg::rom_insn_t      rom_data,
  input  logic                          buzzer,
  input  logic                          ss_begin_reset,
  input  logic                          ss_halt,
  output logic                          clk_en,
  output logic                          clk_2x_en,
  output logic                          cpu_reset,
  output pacing_pkg::audio_t            audio_l
);
  import bridge_map_pkg::*;

  logic           rom_wr_en;
  rom_word_addr_t rom_wr_addr;
  rom_word_t      rom_wr_data;

  settings_if settings_bus ();

  core_settings i_core_settings (
    .clk_sys_117_964 (clk_sys_117_964),
    .reset_turbo_s   (reset_turbo_s),
    .bridge_addr     (bridge_addr),
    .bridge_wr       (bridge_wr),
    .bridge_wr_data  (bridge_wr_data),
    .bridge_rd_data  (bridge_rd_data),
    .settings        (settings_bus.owner)
  );

  rom_loader i_rom_loader (
    .clk_sys_117_964 (clk_sys_117_964),
    .reset_turbo_s   (reset_turbo_s),
    .bridge_addr     (bridge_addr),
    .bridge_wr       (bridge_wr),
    .bridge_wr_data  (bridge_wr_data),
    .wr_en           (rom_wr_en),
    .wr_addr         (rom_wr_addr),
    .wr_data         (rom_wr_data)
  );

  program_rom i_program_rom (
    .clk_sys_117_964 (clk_sys_117_964),
    .wr_en           (rom_wr_en),
    .wr_addr         (rom_wr_addr),
    .wr_data         (rom_wr_data),
    .rom_addr        (rom_addr),
    .rom_data        (rom_data)
  );

  cpu_pacing i_cpu_pacing (
    .clk_sys_117_964 (clk_sys_117_964),
    .reset_turbo_s   (reset_turbo_s),
    .settings        (settings_bus.user),
    .buzzer          (buzzer),
    .ss_begin_reset  (ss_begin_reset),
    .ss_halt         (ss_halt),
    .clk_en          (clk_en),
    .clk_2x_en       (clk_2x_en),
    .cpu_reset       (cpu_reset),
    .audio_l         (audio_l)
  );

endmodule

//--- tests/tb_tama_core.sv
//////////////////////////////////////////////////////////////////////
// tama core testbench
// replays the case file against the DUT and checks every response
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_tama_core;
  import bridge_map_pkg::*;
  import pacing_pkg::*;

  logic           clk_sys_117_964;
  logic           reset_turbo_s;
  bridge_addr_t   bridge_addr;
  logic           bridge_wr;
  bridge_data_t   bridge_wr_data;
  bridge_data_t   bridge_rd_data;
  rom_word_addr_t rom_addr;
  rom_insn_t      rom_data;
  logic           buzzer;
  logic           ss_begin_reset;
  logic           ss_halt;
  logic           clk_en;
  logic           clk_2x_en;
  logic           cpu_reset;
  audio_t         audio_l;

  int cycles = 0;
  int cycle_limit = 0;
  int budget = 0;

  tama_core i_tama_core (.*);

  initial begin
    clk_sys_117_964 = 1'b0;
    forever #5 clk_sys_117_964 = ~clk_sys_117_964;
  end

  // watchdog, limit is set once the case file has been sized
  always @(posedge clk_sys_117_964) begin
    cycles <= cycles + 1;
    if (cycle_limit != 0 && cycles > cycle_limit) begin
      $display("timeout: no finish after %0d cycles", cycles);
      $display("TEST RESULT: FAIL");
      $fatal(1, "simulation timeout");
    end
  end

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual, input int tol);
    int diff;
    diff = int'(actual) - int'(expected);
    if (diff > tol || diff < -tol) begin
      $display("ERR %s expected %0h actual %0h", name, expected, actual);
      $display("TEST RESULT: FAIL");
      $fatal(1, "check failed");
    end
  endtask

  // writes are kept at least four cycles apart
  task automatic bridge_write(input bridge_addr_t addr, input bridge_data_t data);
    repeat (3) @(posedge clk_sys_117_964);
    bridge_addr    <= addr;
    bridge_wr_data <= data;
    bridge_wr      <= 1'b1;
    @(posedge clk_sys_117_964);
    bridge_wr <= 1'b0;
  endtask

  // sync to a clk_en pulse unless halted, then count both enables
  task automatic count_enables(input int window, input bit halt,
                               output int n_en, output int n_2x);
    n_en = 0;
    n_2x = 0;
    if (!halt) begin
      @(negedge clk_sys_117_964);
      while (!clk_en) @(negedge clk_sys_117_964);
    end
    @(posedge clk_sys_117_964);
    ss_halt <= halt;
    repeat (window) begin
      @(negedge clk_sys_117_964);
      if (clk_en) n_en++;
      if (clk_2x_en) n_2x++;
    end
    @(posedge clk_sys_117_964);
    ss_halt <= 1'b0;
  endtask

  // worst case cycles per case, the sync wait can take a full 1x period
  function automatic int case_budget(input byte op, input logic [31:0] a);
    case (op)
      "C", "F": return int'(a) + BASE_DIV_COUNT + 10;
      "S":      return SS_RESET_TICKS * (BASE_DIV_COUNT / 2 + 1) + 10;
      "X":      return EXT_RESET_CYCLES + 10;
      default:  return 10;
    endcase
  endfunction

  task automatic run_case(input string name, input byte op,
                          input logic [31:0] a, input logic [31:0] b, input logic [31:0] c);
    int n_en;
    int n_2x;
    int n;
    n = 0;
    case (op)
      "W": bridge_write(a, b);
      "R": begin
        @(posedge clk_sys_117_964);
        bridge_addr <= a;
        @(negedge clk_sys_117_964);
        check_value(name, b, bridge_rd_data, 0);
      end
      "M": begin
        repeat (2) @(posedge clk_sys_117_964);
        rom_addr <= rom_word_addr_t'(a);
        @(posedge clk_sys_117_964);
        @(negedge clk_sys_117_964);
        check_value(name, b, 32'(rom_data), 0);
      end
      "C": begin
        count_enables(int'(a), c[0], n_en, n_2x);
        check_value(name, b, n_en, c[0] ? 0 : 1);
      end
      "F": begin
        count_enables(int'(a), c[0], n_en, n_2x);
        check_value(name, b, n_2x, 0);
      end
      "S", "X": begin
        if (op == "X") begin
          bridge_write(ADDR_RESET, '0);
        end else begin
          @(posedge clk_sys_117_964);
          ss_begin_reset <= 1'b1;
          @(posedge clk_sys_117_964);
          ss_begin_reset <= 1'b0;
        end
        // savestate reset counts 2x ticks, external reset counts cycles
        @(negedge clk_sys_117_964);
        while (cpu_reset) begin
          if (op == "X" || clk_2x_en) n++;
          @(negedge clk_sys_117_964);
        end
        check_value(name, b, n, 0);
      end
      "B": begin
        @(posedge clk_sys_117_964);
        buzzer <= 1'b1;
        @(posedge clk_sys_117_964);
        buzzer <= 1'b0;
        repeat (2) @(posedge clk_sys_117_964);
      end
      "A": begin
        @(posedge clk_sys_117_964);
        buzzer <= a[0];
        @(negedge clk_sys_117_964);
        check_value(name, b, 32'(audio_l), 0);
        @(posedge clk_sys_117_964);
        buzzer <= 1'b0;
      end
      default: begin
        $display("case %s has an unknown operation", name);
        $display("TEST RESULT: FAIL");
        $fatal(1, "bad case file");
      end
    endcase
  endtask

  // first pass sizes the run, second pass drives the DUT
  task automatic play_cases(input bit execute);
    int          fd;
    string       line;
    string       name;
    string       op;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    fd = $fopen("tests/tama_cases.txt", "r");
    if (fd == 0) begin
      $display("could not open tests/tama_cases.txt");
      $display("TEST RESULT: FAIL");
      $fatal(1, "missing case file");
    end
    while ($fgets(line, fd) != 0) begin
      if (line.len() == 0 || line.getc(0) == "#") continue;
      if ($sscanf(line, "%s %s %h %h %h", name, op, a, b, c) != 5) continue;
      if (execute) run_case(name, op.getc(0), a, b, c);
      else budget += case_budget(op.getc(0), a);
    end
    $fclose(fd);
  endtask

  //////////////////////////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    reset_turbo_s  = 1'b1;
    bridge_addr    = '0;
    bridge_wr      = 1'b0;
    bridge_wr_data = '0;
    rom_addr       = '0;
    buzzer         = 1'b0;
    ss_begin_reset = 1'b0;
    ss_halt        = 1'b0;
    play_cases(1'b0);
    // case windows and reset plus 20 percent
    cycle_limit = (budget + 8) * 6 / 5;
    repeat (8) @(posedge clk_sys_117_964);
    reset_turbo_s <= 1'b0;
    play_cases(1'b1);
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

//--- files.f
design/bridge_map_pkg.sv
design/pacing_pkg.sv
design/settings_if.sv
design/core_settings.sv
design/rom_loader.sv
design/program_rom.sv
design/cpu_pacing.sv
design/tama_core.sv
tests/tb_tama_core.sv

//--- Makefile
# Verilator flow for the tama core testbench

TOP = tb_tama_core

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -Wno-fatal \
		--top-module $(TOP) -f files.f

sim:
	verilator --binary --timing --assert -Wno-fatal \
		--top-module $(TOP) -Mdir obj_dir -f files.f
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "TEST RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

//--- tests/tama_cases.txt
# columns: case_name op a b c, operands in hex
# W addr data | R addr expect | M word expect | C/F window count halt | S,X - expect | B | A level expect
turbo_3     W 100 3 0
turbo_3     R 100 3 0
turbo_mask  W 100 6 0
turbo_mask  R 100 2 0
rd_other    R 104 0 0
rom_a       W 10000020 12345678 0
rom_a_hi    M 10 412 0
rom_a_lo    M 11 856 0
rom_b       W 10003ffc a1b2c3d4 0
rom_b_hi    M 1ffe 2a1 0
rom_b_lo    M 1fff 4c3 0
speed_1x    W 100 0 0
speed_1x    C 2a33 3 0
speed_4x    W 100 1 0
speed_4x    C 2332 a 0
speed_50x   W 100 2 0
speed_50x   C 1c84 64 0
ss_reset    S 0 4 0
speed_full  W 100 3 0
speed_full  C 3e8 1f4 0
speed_full  F 3e8 3e8 0
halt_en     C 3e8 0 1
halt_2x     F 3e8 0 1
ext_reset   X 0 40 0
no_cancel   W 100 2 0
no_cancel   B 0 0 0
no_cancel   R 100 2 0
cancel_on   W 104 1 0
cancel      B 0 0 0
cancel      R 100 0 0
audio_on    A 1 1fff 0
audio_low   A 0 0 0
sound_off   W 10 1 0
audio_off   A 1 0 0
